//--- tb.f
+incdir+source
source/disp_pkg.sv
source/axil_regs.sv
source/bin_to_bcd.sv
source/digit_scan.sv
source/disp_top.sv
test/disp_sva.sv
test/disp_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = disp_tb
FILELIST  = tb.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# fails unless the pass message shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/disp_tb.sv
// display controller testbench with clock, reset, AXI4-Lite tasks, reference model and checks
`timescale 1ns/10ps
`default_nettype none

`include "disp_defs.svh"

module disp_tb;
  import disp_pkg::*;

  localparam int WAIT_LIMIT  = 40;
  localparam int POLL_LIMIT  = 30;
  localparam int CONV_CYCLES = 11;

  logic      CLKOUTseg;
  logic      rst_n;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  disp_out_t disp;

  integer     seed;
  int         error_count;
  int         timeout_count;
  int         cycle_cnt;
  logic       monitor_on;
  logic [9:0] last_value;

  // reference model state
  scan_ctrl_t model_ctrl;
  bcd_t       exp_bcd;
  logic [1:0] model_state;
  logic [1:0] model_prev;
  disp_out_t  exp_disp;

  disp_top i_disp_top (
    .CLKOUTseg (CLKOUTseg),
    .rst_n     (rst_n),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .disp      (disp)
  );

  always #50 CLKOUTseg = ~CLKOUTseg;

  // a..g active high, a in the top bit
  function automatic logic [6:0] segments_for(input logic [3:0] d);
    case (d)
      4'd0:    segments_for = 7'b1111110;
      4'd1:    segments_for = 7'b0110000;
      4'd2:    segments_for = 7'b1101101;
      4'd3:    segments_for = 7'b1111001;
      4'd4:    segments_for = 7'b0110011;
      4'd5:    segments_for = 7'b1011011;
      4'd6:    segments_for = 7'b1011111;
      4'd7:    segments_for = 7'b1110000;
      4'd8:    segments_for = 7'b1111111;
      4'd9:    segments_for = 7'b1111011;
      default: segments_for = 7'b0000000;
    endcase
  endfunction

  function automatic bcd_t decimal_digits(input logic [9:0] v);
    int   n;
    bcd_t r;
    n = (v > 10'd999) ? 999 : int'(v);
    r.hundreds = 4'(n / 100);
    r.tens     = 4'((n / 10) % 10);
    r.units    = 4'(n % 10);
    return r;
  endfunction

  function automatic logic [1:0] scan_next(input logic [1:0] s, input scan_ctrl_t c);
    if (!c.enable) return 2'd0;
    if (!c.scan) return 2'd1;
    return s + 2'd1;
  endfunction

  // idle state shows 0 on the units position
  function automatic disp_out_t expected_display(input logic [1:0] s, input bcd_t b);
    disp_out_t d;
    d.position = (s == 2'd0) ? 2'b01 : s;
    case (s)
      2'd1:    d.digit = b.units;
      2'd2:    d.digit = b.tens;
      2'd3:    d.digit = b.hundreds;
      default: d.digit = 4'd0;
    endcase
    d.segments = segments_for(d.digit);
    return d;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t: %s (got %0h, expected %0h)", $time, msg, actual,
               expected);
      error_count++;
    end
  endtask

  task automatic finish_run();
    $display("check failures: %0d, timeouts: %0d", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout at %0t: no response while waiting for %s", $time, what);
    timeout_count++;
    finish_run();
  endtask

  // returns on the falling edge where bvalid is first seen
  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int   waited;
    logic aw_go;
    logic w_go;
    waited = 0;
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = addr;
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    axil_req.wstrb   = 4'hF;
    axil_req.bready  = 1'b1;
    while (axil_req.awvalid || axil_req.wvalid) begin
      aw_go = axil_req.awvalid && axil_rsp.awready;
      w_go  = axil_req.wvalid && axil_rsp.wready;
      @(negedge CLKOUTseg);
      if (aw_go) axil_req.awvalid = 1'b0;
      if (w_go) axil_req.wvalid = 1'b0;
      waited++;
      if (waited > WAIT_LIMIT) abort_on_timeout("write address and data handshake");
    end
    waited = 0;
    while (!axil_rsp.bvalid) begin
      @(negedge CLKOUTseg);
      waited++;
      if (waited > WAIT_LIMIT) abort_on_timeout("write response");
    end
    resp = axil_rsp.bresp;
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int   waited;
    logic ar_go;
    waited = 0;
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = addr;
    axil_req.rready  = 1'b1;
    while (axil_req.arvalid) begin
      ar_go = axil_rsp.arready;
      @(negedge CLKOUTseg);
      if (ar_go) axil_req.arvalid = 1'b0;
      waited++;
      if (waited > WAIT_LIMIT) abort_on_timeout("read address handshake");
    end
    waited = 0;
    while (!axil_rsp.rvalid) begin
      @(negedge CLKOUTseg);
      waited++;
      if (waited > WAIT_LIMIT) abort_on_timeout("read data");
    end
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
  endtask

  // new control is live on the edge that raised bvalid
  task automatic write_ctrl(input logic [1:0] bits);
    logic [1:0] resp;
    axil_write(`DISP_REG_CTRL, {30'd0, bits}, resp);
    model_ctrl = scan_ctrl_t'(bits);
    check_value(32'(resp), 32'd0, "CTRL write response");
  endtask

  task automatic wait_conversion();
    logic [31:0] status;
    logic [1:0]  resp;
    int          polls;
    polls  = 0;
    status = 32'd1;
    while (status[0]) begin
      axil_read(`DISP_REG_STATUS, status, resp);
      check_value(32'(resp), 32'd0, "STATUS read response");
      polls++;
      if (polls > POLL_LIMIT) abort_on_timeout("conversion to finish");
    end
  endtask

  task automatic check_bcd(input logic [9:0] value);
    logic [31:0] rdata;
    logic [1:0]  resp;
    exp_bcd    = decimal_digits(value);
    last_value = value;
    axil_read(`DISP_REG_BCD, rdata, resp);
    check_value(rdata, 32'(exp_bcd), "BCD of converted value");
  endtask

  task automatic convert_value(input logic [31:0] data);
    logic [1:0] resp;
    axil_write(`DISP_REG_VALUE, data, resp);
    check_value(32'(resp), 32'd0, "VALUE write response");
    wait_conversion();
    check_bcd(data[9:0]);
  endtask

  task automatic expect_steady_display(input logic [1:0] pos, input logic [3:0] dig,
                                       input int n);
    repeat (n) begin
      @(negedge CLKOUTseg);
      check_value(32'(disp.position), 32'(pos), "display position");
      check_value(32'(disp.digit), 32'(dig), "display digit");
      check_value(32'(disp.segments), 32'(segments_for(dig)), "display segments");
    end
  endtask

  // scan model, one step per rising edge
  always @(posedge CLKOUTseg) begin
    cycle_cnt <= cycle_cnt + 1;
    if (!rst_n) begin
      model_state <= 2'd0;
      model_prev  <= 2'd0;
    end else begin
      model_prev  <= model_state;
      model_state <= scan_next(model_state, model_ctrl);
    end
  end

  always @(negedge CLKOUTseg) begin
    if (monitor_on) begin
      exp_disp = expected_display(model_prev, exp_bcd);
      check_value(32'(disp), 32'(exp_disp), "display output against model");
    end
  end

  initial begin
    logic [31:0] rnd;
    logic [31:0] first_value;
    logic [31:0] rdata;
    logic [1:0]  resp;
    int          t_first;
    seed          = 32'h1173_ee85;
    CLKOUTseg     = 1'b0;
    rst_n         = 1'b0;
    axil_req      = '0;
    error_count   = 0;
    timeout_count = 0;
    cycle_cnt     = 0;
    monitor_on    = 1'b0;
    model_ctrl    = '0;
    exp_bcd       = '0;
    last_value    = '0;
    repeat (2) @(negedge CLKOUTseg);
    rst_n      = 1'b1;
    monitor_on = 1'b1;

    // random values, every fourth one above 999
    for (int i = 0; i < 12; i++) begin
      rnd = $random(seed);
      if (i % 4 == 3) rnd[9:0] = 10'd1000 + {6'd0, rnd[3:0]};
      convert_value(rnd);
    end

    // second write is held off until the first conversion ends
    first_value = $random(seed);
    rnd         = $random(seed);
    axil_write(`DISP_REG_VALUE, first_value, resp);
    check_value(32'(resp), 32'd0, "first VALUE write response");
    t_first = cycle_cnt;
    axil_write(`DISP_REG_VALUE, rnd, resp);
    check_value(32'(resp), 32'd0, "second VALUE write response");
    check_value(32'(cycle_cnt - t_first >= CONV_CYCLES), 32'd1,
                "second VALUE write completed before the first conversion");
    wait_conversion();
    check_bcd(rnd[9:0]);

    write_ctrl(2'b00);
    expect_steady_display(2'b01, 4'd0, 12);

    // units position settles two cycles after the response
    write_ctrl(2'b01);
    @(negedge CLKOUTseg);
    expect_steady_display(2'b01, exp_bcd.units, 12);

    write_ctrl(2'b11);
    repeat (12) @(negedge CLKOUTseg);
    for (int i = 0; i < 10; i++) begin
      rnd = $random(seed);
      write_ctrl(rnd[2] ? 2'b11 : rnd[1:0]);
      repeat (int'(rnd[7:4]) + 2) @(negedge CLKOUTseg);
    end

    write_ctrl(2'b10);
    axil_read(`DISP_REG_CTRL, rdata, resp);
    check_value(rdata, 32'd2, "CTRL read back");
    check_value(32'(resp), 32'd0, "CTRL read response");
    axil_write(4'h6, 32'h3, resp);
    check_value(32'(resp), 32'd2, "unmapped write response");
    axil_read(`DISP_REG_CTRL, rdata, resp);
    check_value(rdata, 32'd2, "CTRL after unmapped write");
    axil_read(`DISP_REG_VALUE, rdata, resp);
    check_value(rdata, 32'(last_value), "VALUE after unmapped write");
    axil_read(4'hA, rdata, resp);
    check_value(32'(resp), 32'd2, "unmapped read response");
    repeat (4) @(negedge CLKOUTseg);
    finish_run();
  end

endmodule

`default_nettype wire

//--- test/disp_sva.sv
// concurrent assertions on the digit scanner and their bind into digit_scan
`timescale 1ns/10ps
`default_nettype none

module disp_sva (
  input logic                 CLKOUTseg,
  input logic                 rst_n,
  input disp_pkg::scan_ctrl_t ctrl,
  input disp_pkg::bcd_t       digits,
  input logic [1:0]           scan_state,
  input disp_pkg::disp_out_t  disp
);

  // position and digit the current state should show one cycle later
  logic [5:0] mapped;

  always_comb begin
    case (scan_state)
      2'b01:   mapped = {2'b01, digits.units};
      2'b10:   mapped = {2'b10, digits.tens};
      2'b11:   mapped = {2'b11, digits.hundreds};
      default: mapped = {2'b01, 4'd0};
    endcase
  end

  a_no_unknown: assert property (@(posedge CLKOUTseg)
    rst_n |-> !$isunknown({scan_state, disp}))
    else $error("scanner state or display output unknown");

  a_position_valid: assert property (@(posedge CLKOUTseg) disable iff (!rst_n)
    disp.position != 2'b00)
    else $error("display position code 00");

  a_scan_disabled: assert property (@(posedge CLKOUTseg) disable iff (!rst_n)
    !ctrl.enable |=> scan_state == 2'b00)
    else $error("scan state not zero while disabled");

  a_scan_parked: assert property (@(posedge CLKOUTseg) disable iff (!rst_n)
    ctrl.enable && !ctrl.scan |=> scan_state == 2'b01)
    else $error("scan state not on units with scanning off");

  a_scan_step: assert property (@(posedge CLKOUTseg) disable iff (!rst_n)
    ctrl.enable && ctrl.scan |=> scan_state == 2'($past(scan_state) + 2'd1))
    else $error("scan state did not advance by one");

  a_output_map: assert property (@(posedge CLKOUTseg) disable iff (!rst_n)
    1'b1 |=> {disp.position, disp.digit} == $past(mapped))
    else $error("display output does not follow previous scan state");

endmodule

bind digit_scan disp_sva i_disp_sva (
  .CLKOUTseg  (CLKOUTseg),
  .rst_n      (rst_n),
  .ctrl       (ctrl),
  .digits     (digits),
  .scan_state (scan_state),
  .disp       (disp)
);

`default_nettype wire

//--- source/disp_top.sv
// display controller top level with register block, BCD converter and digit scanner
`timescale 1ns/10ps
`default_nettype none

`include "disp_defs.svh"

module disp_top (
  input  logic                CLKOUTseg,
  input  logic                rst_n,
  input  disp_pkg::axil_req_t axil_req,
  output disp_pkg::axil_rsp_t axil_rsp,
  output disp_pkg::disp_out_t disp
);
  import disp_pkg::*;

  logic                     conv_start;
  logic [`DISP_VALUE_W-1:0] conv_value;
  logic                     conv_busy;
  bcd_t                     conv_result;
  scan_ctrl_t               scan_ctrl;

  axil_regs i_axil_regs (
    .CLKOUTseg   (CLKOUTseg),
    .rst_n       (rst_n),
    .axil_req    (axil_req),
    .axil_rsp    (axil_rsp),
    .conv_start  (conv_start),
    .conv_value  (conv_value),
    .conv_busy   (conv_busy),
    .conv_result (conv_result),
    .scan_ctrl   (scan_ctrl)
  );

  bin_to_bcd i_bin_to_bcd (
    .CLKOUTseg (CLKOUTseg),
    .rst_n     (rst_n),
    .start     (conv_start),
    .value     (conv_value),
    .busy      (conv_busy),
    .result    (conv_result)
  );

  // scanner reads the held result directly
  digit_scan i_digit_scan (
    .CLKOUTseg (CLKOUTseg),
    .rst_n     (rst_n),
    .ctrl      (scan_ctrl),
    .digits    (conv_result),
    .disp      (disp)
  );

endmodule

`default_nettype wire

//--- source/digit_scan.sv
// digit scan FSM, digit multiplexer and seven-segment decoder
`timescale 1ns/10ps
`default_nettype none

module digit_scan (
  input  logic                 CLKOUTseg,
  input  logic                 rst_n,
  input  disp_pkg::scan_ctrl_t ctrl,
  input  disp_pkg::bcd_t       digits,
  output disp_pkg::disp_out_t  disp
);
  import disp_pkg::*;

  localparam logic [1:0] SCAN_ZERO     = 2'b00;
  localparam logic [1:0] SCAN_UNITS    = 2'b01;
  localparam logic [1:0] SCAN_TENS     = 2'b10;
  localparam logic [1:0] SCAN_HUNDREDS = 2'b11;

  logic [1:0] scan_state;
  disp_out_t  disp_next;

  // active high, a is bit 6
  function automatic logic [6:0] seg_decode(input logic [3:0] d);
    case (d)
      4'd0:    seg_decode = 7'b1111110;
      4'd1:    seg_decode = 7'b0110000;
      4'd2:    seg_decode = 7'b1101101;
      4'd3:    seg_decode = 7'b1111001;
      4'd4:    seg_decode = 7'b0110011;
      4'd5:    seg_decode = 7'b1011011;
      4'd6:    seg_decode = 7'b1011111;
      4'd7:    seg_decode = 7'b1110000;
      4'd8:    seg_decode = 7'b1111111;
      4'd9:    seg_decode = 7'b1111011;
      default: seg_decode = 7'b0000000;
    endcase
  endfunction

  // zero when disabled, parked on units without scan, else cycle
  always_ff @(posedge CLKOUTseg) begin
    if (!rst_n) begin
      scan_state <= SCAN_ZERO;
    end else if (!ctrl.enable) begin
      scan_state <= SCAN_ZERO;
    end else if (!ctrl.scan) begin
      scan_state <= SCAN_UNITS;
    end else begin
      scan_state <= scan_state + 2'd1;
    end
  end

  always_comb begin
    case (scan_state)
      SCAN_UNITS: begin
        disp_next.position = 2'b01;
        disp_next.digit    = digits.units;
      end
      SCAN_TENS: begin
        disp_next.position = 2'b10;
        disp_next.digit    = digits.tens;
      end
      SCAN_HUNDREDS: begin
        disp_next.position = 2'b11;
        disp_next.digit    = digits.hundreds;
      end
      // idle state lights a 0 on the units position
      default: begin
        disp_next.position = 2'b01;
        disp_next.digit    = 4'd0;
      end
    endcase
    disp_next.segments = seg_decode(disp_next.digit);
  end

  // one cycle behind the scan state
  always_ff @(posedge CLKOUTseg) begin
    if (!rst_n) begin
      disp <= '{position: 2'b01, digit: 4'd0, segments: 7'b1111110};
    end else begin
      disp <= disp_next;
    end
  end

endmodule

`default_nettype wire

//--- source/bin_to_bcd.sv
// sequential double-dabble binary to BCD converter, input clamped to 999
`timescale 1ns/10ps
`default_nettype none

`include "disp_defs.svh"

module bin_to_bcd (
  input  logic                     CLKOUTseg,
  input  logic                     rst_n,
  input  logic                     start,
  input  logic [`DISP_VALUE_W-1:0] value,
  output logic                     busy,
  output disp_pkg::bcd_t           result
);

  // three BCD nibbles above the binary field
  localparam int unsigned SHIFT_W = `DISP_VALUE_W + 12;
  localparam logic [3:0]  LAST_STEP = 4'(`DISP_VALUE_W - 1);

  logic [SHIFT_W-1:0]       shift_reg;
  logic [SHIFT_W-1:0]       shift_next;
  logic [11:0]              bcd_adj;
  logic [3:0]               step_cnt;
  logic [`DISP_VALUE_W-1:0] value_clamped;

  assign value_clamped = (value > `DISP_MAX_VALUE) ? `DISP_MAX_VALUE : value;

  // add 3 to every nibble of 5 or more, then shift one bit
  always_comb begin
    bcd_adj = shift_reg[SHIFT_W-1:`DISP_VALUE_W];
    for (int i = 0; i < 3; i++) begin
      if (bcd_adj[i*4 +: 4] >= 4'd5) begin
        bcd_adj[i*4 +: 4] = bcd_adj[i*4 +: 4] + 4'd3;
      end
    end
    shift_next = {bcd_adj, shift_reg[`DISP_VALUE_W-1:0]} << 1;
  end

  always_ff @(posedge CLKOUTseg) begin
    if (start) begin
      shift_reg <= {12'd0, value_clamped};
    end else if (busy) begin
      shift_reg <= shift_next;
    end
  end

  // load cycle then ten shifts, result copied out on the last one
  always_ff @(posedge CLKOUTseg) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      step_cnt <= '0;
      result   <= '0;
    end else if (start) begin
      busy     <= 1'b1;
      step_cnt <= '0;
    end else if (busy) begin
      if (step_cnt == LAST_STEP) begin
        busy            <= 1'b0;
        step_cnt        <= '0;
        result.hundreds <= shift_next[SHIFT_W-1 -: 4];
        result.tens     <= shift_next[SHIFT_W-5 -: 4];
        result.units    <= shift_next[SHIFT_W-9 -: 4];
      end else begin
        step_cnt <= step_cnt + 4'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/axil_regs.sv
// AXI4-Lite slave with value, control, status and BCD result registers
`timescale 1ns/10ps
`default_nettype none

`include "disp_defs.svh"

module axil_regs (
  input  logic                     CLKOUTseg,
  input  logic                     rst_n,
  input  disp_pkg::axil_req_t      axil_req,
  output disp_pkg::axil_rsp_t      axil_rsp,
  output logic                     conv_start,
  output logic [`DISP_VALUE_W-1:0] conv_value,
  input  logic                     conv_busy,
  input  disp_pkg::bcd_t           conv_result,
  output disp_pkg::scan_ctrl_t     scan_ctrl
);
  import disp_pkg::*;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // write channel
  logic                     aw_done;
  logic [`DISP_ADDR_W-1:0]  aw_addr_q;
  logic                     w_done;
  logic [31:0]              w_data_q;
  logic [3:0]               w_strb_q;
  logic                     bvalid_q;
  logic [1:0]               bresp_q;

  // read channel
  logic                     rvalid_q;
  logic [31:0]              rdata_q;
  logic [1:0]               rresp_q;

  logic [`DISP_VALUE_W-1:0] value_q;
  scan_ctrl_t               ctrl_q;

  logic                     awready;
  logic                     wready;
  logic                     arready;
  logic                     aw_hs;
  logic                     w_hs;
  logic                     ar_hs;
  logic                     wr_fire;
  logic [`DISP_ADDR_W-1:0]  wr_addr;
  logic [31:0]              wr_data;
  logic [3:0]               wr_strb;
  logic                     wr_mapped;
  logic [31:0]              rd_data;
  logic                     rd_mapped;

  // no new address while a conversion runs or is about to start
  assign awready = !aw_done && !bvalid_q && !conv_busy && !conv_start;
  assign wready  = !w_done && !bvalid_q;
  assign arready = !rvalid_q;

  assign aw_hs = axil_req.awvalid && awready;
  assign w_hs  = axil_req.wvalid && wready;
  assign ar_hs = axil_req.arvalid && arready;

  // commit once both channels are in, whichever came first
  assign wr_fire = (aw_done || aw_hs) && (w_done || w_hs);
  assign wr_addr = aw_done ? aw_addr_q : axil_req.awaddr;
  assign wr_data = w_done ? w_data_q : axil_req.wdata;
  assign wr_strb = w_done ? w_strb_q : axil_req.wstrb;

  assign wr_mapped = wr_addr inside {`DISP_REG_VALUE, `DISP_REG_CTRL,
                                     `DISP_REG_STATUS, `DISP_REG_BCD};

  always_comb begin
    rd_data   = '0;
    rd_mapped = 1'b1;
    case (axil_req.araddr)
      `DISP_REG_VALUE:  rd_data = 32'(value_q);
      `DISP_REG_CTRL:   rd_data = 32'(ctrl_q);
      // a pending start already counts as busy
      `DISP_REG_STATUS: rd_data = 32'(conv_busy || conv_start);
      `DISP_REG_BCD:    rd_data = 32'(conv_result);
      default:          rd_mapped = 1'b0;
    endcase
  end

  always_ff @(posedge CLKOUTseg) begin
    if (!rst_n) begin
      aw_done  <= 1'b0;
      w_done   <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_fire) begin
        aw_done <= 1'b0;
        w_done  <= 1'b0;
      end else begin
        if (aw_hs) aw_done <= 1'b1;
        if (w_hs) w_done <= 1'b1;
      end
      if (wr_fire) begin
        bvalid_q <= 1'b1;
      end else if (axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
      if (ar_hs) begin
        rvalid_q <= 1'b1;
      end else if (axil_req.rready) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLKOUTseg) begin
    if (aw_hs) aw_addr_q <= axil_req.awaddr;
    if (w_hs) begin
      w_data_q <= axil_req.wdata;
      w_strb_q <= axil_req.wstrb;
    end
    if (wr_fire) bresp_q <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
    if (ar_hs) begin
      rdata_q <= rd_data;
      rresp_q <= rd_mapped ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // ctrl changes on the same edge that raises bvalid
  always_ff @(posedge CLKOUTseg) begin
    if (!rst_n) begin
      value_q    <= '0;
      ctrl_q     <= '0;
      conv_start <= 1'b0;
    end else begin
      conv_start <= 1'b0;
      if (wr_fire) begin
        case (wr_addr)
          `DISP_REG_VALUE: begin
            if (wr_strb[0]) value_q[7:0] <= wr_data[7:0];
            if (wr_strb[1]) value_q[`DISP_VALUE_W-1:8] <= wr_data[`DISP_VALUE_W-1:8];
            conv_start <= 1'b1;
          end
          `DISP_REG_CTRL: begin
            if (wr_strb[0]) ctrl_q <= scan_ctrl_t'(wr_data[1:0]);
          end
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    axil_rsp.awready = awready;
    axil_rsp.wready  = wready;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.bresp   = bresp_q;
    axil_rsp.arready = arready;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
  end

  assign conv_value = value_q;
  assign scan_ctrl  = ctrl_q;

endmodule

`default_nettype wire

//--- source/disp_pkg.sv
// AXI4-Lite request and response, BCD digit, scan control and display output types
`default_nettype none

`include "disp_defs.svh"

package disp_pkg;

  // master to slave
  typedef struct packed {
    logic                    awvalid;
    logic [`DISP_ADDR_W-1:0] awaddr;
    logic                    wvalid;
    logic [31:0]             wdata;
    logic [3:0]              wstrb;
    logic                    bready;
    logic                    arvalid;
    logic [`DISP_ADDR_W-1:0] araddr;
    logic                    rready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

  // hundreds land in bits 11..8
  typedef struct packed {
    logic [3:0] hundreds;
    logic [3:0] tens;
    logic [3:0] units;
  } bcd_t;

  // enable sits in bit 0, scan in bit 1
  typedef struct packed {
    logic scan;
    logic enable;
  } scan_ctrl_t;

  // position 01 units, 10 tens, 11 hundreds; segments a..g, a in the top bit
  typedef struct packed {
    logic [1:0] position;
    logic [3:0] digit;
    logic [6:0] segments;
  } disp_out_t;

endpackage

`default_nettype wire

//--- source/disp_defs.svh
// register offsets, maximum display value and bus widths
`ifndef DISP_DEFS_SVH
`define DISP_DEFS_SVH

// register offsets on the AXI4-Lite port
`define DISP_REG_VALUE  4'h0
`define DISP_REG_CTRL   4'h4
`define DISP_REG_STATUS 4'h8
`define DISP_REG_BCD    4'hC

// largest value three digits can show
`define DISP_MAX_VALUE  10'd999

// binary value width
`define DISP_VALUE_W    10

// byte address width of the register port
`define DISP_ADDR_W     4

`endif
